// File: sim.f
hw/arm_pkg.sv
hw/regfile_if.sv
hw/arm_regfile.sv
hw/arm_shifter.sv
hw/arm_alu.sv
hw/arm_cond.sv
hw/arm_ctrl.sv
hw/arm_core.sv
verification/arm_core_chk.sv
verification/arm_store_monitor.sv
verification/tb_arm_core.sv

// File: Makefile
TOP = tb_arm_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir

// File: verification/tb_arm_core.sv
`timescale 1ns/1ps

module tb_arm_core import arm_pkg::*; ();

	localparam int PROG_LEN = 45;
	localparam int EXP_LEN = 15;
	localparam int MAX_CYCLES = PROG_LEN * 10;

	logic clk;
	logic rstn;
	word_t mem_addr;
	word_t mem_wdata;
	word_t mem_rdata;
	logic mem_read;
	logic mem_write;
	logic mem_ok;

	word_t mem [0:255]; // 1 KiB window at RESET_PC
	word_t prog [PROG_LEN];
	logic [63:0] expected [EXP_LEN];
	int seed;
	int wait_left;
	logic busy;
	int cycles;
	logic done;
	int checked;
	int errors;

	arm_core arm_core_i (
		.clk(clk), .rstn(rstn), .o_mem_addr(mem_addr), .o_mem_wdata(mem_wdata),
		.o_mem_read(mem_read), .o_mem_write(mem_write),
		.i_mem_rdata(mem_rdata), .i_mem_ok(mem_ok)
	);

	arm_store_monitor #(.N_EXP(EXP_LEN)) u_monitor (
		.clk(clk), .rstn(rstn), .i_mem_addr(mem_addr), .i_mem_wdata(mem_wdata),
		.i_mem_write(mem_write), .i_mem_ok(mem_ok), .i_expected(expected),
		.o_done(done), .o_checked(checked), .o_errors(errors)
	);

	bind arm_core arm_core_chk u_bus_chk (
		.clk(clk), .rstn(rstn), .i_mem_addr(o_mem_addr), .i_mem_read(o_mem_read),
		.i_mem_write(o_mem_write), .i_mem_ok(i_mem_ok)
	);

	always #50 clk = ~clk;

	// memory model answering after 0 to 3 wait cycles
	always @(negedge clk) begin
		if (!(mem_read || mem_write)) begin
			mem_ok = 1'b0;
			busy = 1'b0;
		end else begin
			if (!busy) begin
				wait_left = $random(seed) & 3;
				busy = 1'b1;
			end
			if (wait_left == 0) begin
				mem_ok = 1'b1;
				busy = 1'b0;
				if (mem_write)
					mem[mem_addr[9:2]] = mem_wdata;
				else
					mem_rdata = mem[mem_addr[9:2]];
			end else begin
				mem_ok = 1'b0;
				wait_left--;
			end
		end
	end

	initial begin
		clk = 1'b0;
		rstn = 1'b0;
		seed = 89;
		mem_ok = 1'b0;
		mem_rdata = '0;
		busy = 1'b0;
		wait_left = 0;
		cycles = 0;
		prog = '{
			32'he3a0c408, 32'he28ccc02, 32'he3a000ff, 32'he28018ab, // r12 base and r1
			32'he58c1000, 32'he3a02005, 32'he3e04004, 32'he0923004, // adds 5 + -5
			32'h058c2004, 32'h158c0008, 32'he58c300c, // streq, strne
			32'he3a05106, 32'he1a06205, 32'he58c6010, // lsl #4
			32'he1a06225, 32'he58c6014, 32'he1a06245, 32'he58c6018, // lsr, asr
			32'he1a06265, 32'he58c601c, 32'he1a06045, 32'he58c6020, // ror, asr #0
			32'he1a06065, 32'he58c6024, // rrx with c set
			32'he1a06025, 32'he58c6050, // lsr #0 acts as #32
			32'he3a07102, 32'he2578001, 32'ha58c8028, 32'hb58c802c, // subs overflows
			32'h658c7030, 32'he3520006, 32'h258c2034, 32'h358c2038, // cmp borrows
			32'he28c9f41, 32'he599a004, 32'he519b004, 32'he08a300b, // ldr +4, -4
			32'he58c3040, 32'hea000000, 32'he58c0044, // b over a str
			32'heb000000, 32'he58c0048, 32'he58ce04c, 32'heafffffe // bl, spin
		};
		expected = '{
			{32'h0800_0200, 32'h00ab_00ff}, {32'h0800_0204, 32'h0000_0005},
			{32'h0800_020c, 32'h0000_0000}, {32'h0800_0210, 32'h0000_0010},
			{32'h0800_0214, 32'h0800_0000}, {32'h0800_0218, 32'hf800_0000},
			{32'h0800_021c, 32'h1800_0000}, {32'h0800_0220, 32'hffff_ffff},
			{32'h0800_0224, 32'hc000_0000}, {32'h0800_0250, 32'h0000_0000},
			{32'h0800_022c, 32'h7fff_ffff}, {32'h0800_0230, 32'h8000_0000},
			{32'h0800_0238, 32'h0000_0005}, {32'h0800_0240, 32'h2345_6789},
			{32'h0800_024c, 32'h0800_00a8}
		};
		for (int i = 0; i < 256; i++)
			mem[i] = ~(RESET_PC + 32'(i * 4)); // fill follows the address
		for (int i = 0; i < PROG_LEN; i++)
			mem[i] = prog[i];
		mem[8'hc0] = 32'h1234_5678; // load data at 0x300
		mem[8'hc2] = 32'h1111_1111; // and at 0x308
		repeat (2) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		while (!done && cycles < MAX_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (!done)
			$display("run timed out after %0d cycles with %0d stores seen", cycles, checked);
		if (arm_core_i.u_bus_chk.fail_count != 0)
			$display("%0d bus protocol assertions failed", arm_core_i.u_bus_chk.fail_count);
		$display("%0d of %0d stores checked, %0d errors, %0d cycles",
			checked, EXP_LEN, errors, cycles);
		if (done && errors == 0 && arm_core_i.u_bus_chk.fail_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: verification/arm_store_monitor.sv
`timescale 1ns/1ps

module arm_store_monitor import arm_pkg::*; #(
	parameter int N_EXP = 1
) (
	input logic clk,
	input logic rstn,
	input word_t i_mem_addr,
	input word_t i_mem_wdata,
	input logic i_mem_write,
	input logic i_mem_ok,
	input logic [63:0] i_expected [N_EXP], // {address, data}
	output logic o_done,
	output int o_checked,
	output int o_errors
);

	int idx;
	word_t exp_addr;
	word_t exp_data;
	logic addr_bad;
	logic data_bad;

	initial begin
		idx = 0;
		o_checked = 0;
		o_errors = 0;
		o_done = 1'b0;
	end

	// a write completes in the cycle where ok is high
	always @(posedge clk) begin
		if (rstn && i_mem_write && i_mem_ok) begin
			if (idx >= N_EXP) begin
				$display("store %0d to %h is not in the expected list", idx, i_mem_addr);
				o_errors++;
			end else begin
				{exp_addr, exp_data} = i_expected[idx];
				addr_bad = (i_mem_addr !== exp_addr);
				data_bad = (i_mem_wdata !== exp_data);
				if (addr_bad && data_bad)
					$display("FAILED store %0d: o_mem_addr %h expected %h, o_mem_wdata %h expected %h",
						idx, i_mem_addr, exp_addr, i_mem_wdata, exp_data);
				else if (addr_bad)
					$display("FAILED store %0d: o_mem_addr %h expected %h",
						idx, i_mem_addr, exp_addr);
				else if (data_bad)
					$display("FAILED store %0d: o_mem_wdata %h expected %h",
						idx, i_mem_wdata, exp_data);
				else
					$display("store %0d ok: %h at %h", idx, i_mem_wdata, i_mem_addr);
				if (addr_bad || data_bad)
					o_errors++;
				o_checked++;
			end
			idx++;
			o_done = (idx == N_EXP);
		end
	end

endmodule

// File: verification/arm_core_chk.sv
`timescale 1ns/1ps

module arm_core_chk import arm_pkg::*; (
	input logic clk,
	input logic rstn,
	input word_t i_mem_addr,
	input logic i_mem_read,
	input logic i_mem_write,
	input logic i_mem_ok
);

	int fail_count = 0;

	no_overlap: assert property (@(posedge clk) disable iff (!rstn)
		!(i_mem_read && i_mem_write))
		else begin
			$error("bus read and write requested in the same cycle");
			fail_count++;
		end

	// a pending request keeps its address and direction until ok
	req_hold: assert property (@(posedge clk) disable iff (!rstn)
		(i_mem_read || i_mem_write) && !i_mem_ok |=>
		(i_mem_addr == $past(i_mem_addr)) && (i_mem_read == $past(i_mem_read))
		&& (i_mem_write == $past(i_mem_write)))
		else begin
			$error("bus request changed before it was acknowledged");
			fail_count++;
		end

	// sampled mid-cycle after the reset state has settled
	quiet_in_reset: assert property (@(negedge clk)
		!rstn |-> !i_mem_read && !i_mem_write)
		else begin
			$error("bus request raised while reset was active");
			fail_count++;
		end

endmodule

// File: hw/arm_core.sv
`timescale 1ns/1ps

module arm_core import arm_pkg::*; (
	input logic clk,
	input logic rstn,
	output word_t o_mem_addr,
	output word_t o_mem_wdata,
	output logic o_mem_read,
	output logic o_mem_write,
	input word_t i_mem_rdata,
	input logic i_mem_ok
);

	regfile_if rf_bus ();

	word_t pc;
	logic imm;
	logic [11:0] op2;
	alu_op_t op;
	cond_t cond;
	flags_t flags;
	logic pass;
	word_t operand;
	logic shift_carry;
	word_t alu_result;
	flags_t alu_flags;
	logic alu_writes;

	arm_regfile u_regfile (
		.clk(clk), .rstn(rstn), .rf(rf_bus.regs), .i_pc(pc)
	);

	arm_shifter u_shifter (
		.rf(rf_bus.dp), .i_imm(imm), .i_op2(op2), .i_carry(flags[1]),
		.o_operand(operand), .o_carry(shift_carry)
	);

	arm_alu u_alu (
		.rf(rf_bus.dp), .i_op(op), .i_operand(operand), .i_flags(flags),
		.i_shift_carry(shift_carry), .o_result(alu_result), .o_flags(alu_flags),
		.o_writes(alu_writes)
	);

	arm_cond u_cond (.i_cond(cond), .i_flags(flags), .o_pass(pass));

	arm_ctrl u_ctrl (
		.clk(clk), .rstn(rstn), .rf(rf_bus.ctrl), .o_pc(pc), .o_imm(imm),
		.o_op2(op2), .o_op(op), .o_cond(cond), .o_flags(flags), .i_pass(pass),
		.i_operand(operand), .i_alu_result(alu_result), .i_alu_flags(alu_flags),
		.i_alu_writes(alu_writes), .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata),
		.o_mem_read(o_mem_read), .o_mem_write(o_mem_write),
		.i_mem_rdata(i_mem_rdata), .i_mem_ok(i_mem_ok)
	);

endmodule

// File: hw/arm_ctrl.sv
`timescale 1ns/1ps

module arm_ctrl import arm_pkg::*; (
	input logic clk,
	input logic rstn,
	regfile_if.ctrl rf,
	output word_t o_pc,
	output logic o_imm,
	output logic [11:0] o_op2,
	output alu_op_t o_op,
	output cond_t o_cond,
	output flags_t o_flags,
	input logic i_pass,
	input word_t i_operand,
	input word_t i_alu_result,
	input flags_t i_alu_flags,
	input logic i_alu_writes,
	output word_t o_mem_addr,
	output word_t o_mem_wdata,
	output logic o_mem_read,
	output logic o_mem_write,
	input word_t i_mem_rdata,
	input logic i_mem_ok
);

	ctrl_state_e state;
	word_t pc;
	flags_t flags;
	word_t ir;

	logic is_dp, is_br, is_mem, is_load;
	logic exec, exec_mem, exec_done;
	reg_idx_t rd;
	word_t offset;
	word_t xfer_addr;
	word_t dp_data;
	word_t br_target;
	word_t next_pc;

	// instruction classes
	assign is_dp = (ir[27:26] == 2'b00) && (ir[25] || !ir[4]);
	assign is_br = (ir[27:25] == 3'b101);
	assign is_mem = (ir[27:25] == 3'b010) && ir[24] && !ir[22] && !ir[21]; // word, pre, no wb
	assign is_load = ir[20];
	assign rd = ir[15:12];

	assign exec = (state == ST_EXEC) && i_pass;
	assign exec_mem = exec && is_mem;
	assign exec_done = !exec_mem || i_mem_ok; // stall on memory back-pressure

	assign offset = {20'h0, ir[11:0]};
	assign xfer_addr = ir[23] ? rf.rn_data + offset : rf.rn_data - offset;
	assign br_target = pc + PC_READ_AHEAD + {{6{ir[23]}}, ir[23:0], 2'b00};
	assign dp_data = i_alu_result;

	assign o_pc = pc;
	assign o_imm = ir[25];
	assign o_op2 = ir[11:0];
	assign o_op = alu_op_t'(ir[24:21]);
	assign o_cond = ir[31:28];
	assign o_flags = flags;

	assign rf.rn_idx = ir[19:16];
	assign rf.rm_idx = ir[3:0];
	assign rf.rd_idx = rd;

	// bus requests
	assign o_mem_read = (state == ST_FETCH) || (exec_mem && is_load);
	assign o_mem_write = exec_mem && !is_load;
	assign o_mem_addr = exec_mem ? xfer_addr : pc;
	assign o_mem_wdata = rf.rd_data;

	// register write-back with r15 going to the pc instead
	always_comb begin
		rf.wr_en = 1'b0;
		rf.wr_idx = rd;
		rf.wr_data = dp_data;
		if (exec) begin
			if (is_br && ir[24]) begin
				rf.wr_en = 1'b1; // bl link
				rf.wr_idx = LR_IDX;
				rf.wr_data = pc + PC_STEP;
			end else if (is_dp) begin
				rf.wr_en = i_alu_writes && (rd != 4'd15);
			end else if (is_mem && is_load) begin
				rf.wr_en = i_mem_ok && (rd != 4'd15);
				rf.wr_data = i_mem_rdata;
			end
		end
	end

	always_comb begin
		next_pc = pc + PC_STEP;
		if (exec) begin
			if (is_br)
				next_pc = br_target;
			else if (is_dp && i_alu_writes && rd == 4'd15)
				next_pc = dp_data;
			else if (is_mem && is_load && rd == 4'd15)
				next_pc = i_mem_rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= ST_INIT;
			pc <= RESET_PC;
			flags <= '0;
		end else begin
			case (state)
				ST_INIT: begin
					pc <= RESET_PC;
					flags <= '0;
					state <= ST_FETCH;
				end
				ST_FETCH: begin
					if (i_mem_ok) begin
						state <= ST_EXEC;
					end
				end
				default: begin
					if (exec_done) begin
						pc <= next_pc;
						if (exec && is_dp && ir[20])
							flags <= i_alu_flags; // s bit
						state <= ST_FETCH;
					end
				end
			endcase
		end
	end

	// instruction register captured at the end of fetch
	always_ff @(posedge clk) begin
		if (state == ST_FETCH && i_mem_ok)
			ir <= i_mem_rdata;
	end

endmodule

// File: hw/arm_cond.sv
`timescale 1ns/1ps

module arm_cond import arm_pkg::*; (
	input cond_t i_cond,
	input flags_t i_flags,
	output logic o_pass
);

	logic n, z, c, v;

	assign {n, z, c, v} = i_flags;

	always_comb begin
		case (i_cond)
			4'h0: o_pass = z; // eq
			4'h1: o_pass = !z;
			4'h2: o_pass = c; // cs
			4'h3: o_pass = !c;
			4'h4: o_pass = n; // mi
			4'h5: o_pass = !n;
			4'h6: o_pass = v; // vs
			4'h7: o_pass = !v;
			4'h8: o_pass = c && !z; // hi
			4'h9: o_pass = !c || z;
			4'ha: o_pass = (n == v); // ge
			4'hb: o_pass = (n != v);
			4'hc: o_pass = !z && (n == v); // gt
			4'hd: o_pass = z || (n != v);
			default: o_pass = 1'b1; // al and 1111
		endcase
	end

endmodule

// File: hw/arm_alu.sv
`timescale 1ns/1ps

module arm_alu import arm_pkg::*; (
	regfile_if.dp rf,
	input alu_op_t i_op,
	input word_t i_operand,
	input flags_t i_flags,
	input logic i_shift_carry,
	output word_t o_result,
	output flags_t o_flags,
	output logic o_writes
);

	word_t a;
	word_t b;
	logic cin;
	logic [32:0] sum;
	logic logical;

	// adder operands with subtraction as a + ~b + 1
	always_comb begin
		a = rf.rn_data;
		b = i_operand;
		cin = 1'b0;
		case (i_op)
			OP_SUB, OP_CMP: begin
				b = ~i_operand;
				cin = 1'b1;
			end
			OP_RSB: begin
				a = i_operand;
				b = ~rf.rn_data;
				cin = 1'b1;
			end
			OP_ADC: cin = i_flags[1];
			OP_SBC: begin
				b = ~i_operand;
				cin = i_flags[1]; // carry is not-borrow
			end
			OP_RSC: begin
				a = i_operand;
				b = ~rf.rn_data;
				cin = i_flags[1];
			end
			default: cin = 1'b0;
		endcase
	end

	assign sum = {1'b0, a} + {1'b0, b} + {32'h0, cin};

	always_comb begin
		case (i_op)
			OP_AND, OP_TST: o_result = rf.rn_data & i_operand;
			OP_EOR, OP_TEQ: o_result = rf.rn_data ^ i_operand;
			OP_ORR: o_result = rf.rn_data | i_operand;
			OP_MOV: o_result = i_operand;
			OP_BIC: o_result = rf.rn_data & ~i_operand;
			OP_MVN: o_result = ~i_operand;
			default: o_result = sum[31:0];
		endcase
	end

	assign logical = (i_op inside {OP_AND, OP_EOR, OP_TST, OP_TEQ,
		OP_ORR, OP_MOV, OP_BIC, OP_MVN});

	assign o_flags[3] = o_result[31];
	assign o_flags[2] = (o_result == '0);
	assign o_flags[1] = logical ? i_shift_carry : sum[32];
	// signed overflow when both inputs agree in sign and the sum does not
	assign o_flags[0] = logical ? i_flags[0] : ((a[31] == b[31]) && (sum[31] != a[31]));

	assign o_writes = !(i_op inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN}); // compares only set flags

endmodule

// File: hw/arm_shifter.sv
`timescale 1ns/1ps

module arm_shifter import arm_pkg::*; (
	regfile_if.dp rf,
	input logic i_imm,
	input logic [11:0] i_op2,
	input logic i_carry,
	output word_t o_operand,
	output logic o_carry
);

	always_comb begin
		logic [32:0] ext;
		logic [63:0] dbl;
		logic [5:0] rot;
		logic [4:0] amt;
		shift_t sh_type;
		word_t rm;

		ext = '0;
		dbl = '0;
		rot = {i_op2[11:8], 1'b0}; // twice the rotate field
		amt = i_op2[11:7];
		sh_type = shift_t'(i_op2[6:5]);
		rm = rf.rm_data;

		if (i_imm) begin
			dbl = {24'h0, i_op2[7:0], 24'h0, i_op2[7:0]} >> rot;
			o_operand = dbl[31:0];
			o_carry = (rot == 6'd0) ? i_carry : dbl[31];
		end else begin
			case (sh_type)
				2'b00: begin // lsl
					ext = {1'b0, rm} << amt;
					o_operand = ext[31:0];
					o_carry = (amt == 5'd0) ? i_carry : ext[32];
				end
				2'b01: begin // lsr where #0 means #32
					ext = {rm, 1'b0} >> amt;
					o_operand = (amt == 5'd0) ? '0 : ext[32:1];
					o_carry = (amt == 5'd0) ? rm[31] : ext[0];
				end
				2'b10: begin // asr where #0 means #32
					ext = $signed({rm, 1'b0}) >>> amt;
					o_operand = (amt == 5'd0) ? {32{rm[31]}} : ext[32:1];
					o_carry = (amt == 5'd0) ? rm[31] : ext[0];
				end
				default: begin // ror or rrx for #0
					dbl = {rm, rm} >> amt;
					o_operand = (amt == 5'd0) ? {i_carry, rm[31:1]} : dbl[31:0];
					o_carry = (amt == 5'd0) ? rm[0] : dbl[31];
				end
			endcase
		end
	end

endmodule

// File: hw/arm_regfile.sv
`timescale 1ns/1ps

module arm_regfile import arm_pkg::*; (
	input logic clk,
	input logic rstn,
	regfile_if.regs rf,
	input word_t i_pc
);

	word_t regs [0:14]; // r0 to r14 while the pc lives in the controller
	word_t pc_view;

	assign pc_view = i_pc + PC_READ_AHEAD;

	// index 15 never selects the array
	assign rf.rn_data = (rf.rn_idx == 4'd15) ? pc_view : regs[rf.rn_idx];
	assign rf.rm_data = (rf.rm_idx == 4'd15) ? pc_view : regs[rf.rm_idx];
	assign rf.rd_data = (rf.rd_idx == 4'd15) ? pc_view : regs[rf.rd_idx];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < 15; i++) begin
				regs[i] <= '0;
			end
		end else if (rf.wr_en && rf.wr_idx != 4'd15) begin
			regs[rf.wr_idx] <= rf.wr_data;
		end
	end

endmodule

// File: hw/regfile_if.sv
`timescale 1ns/1ps

interface regfile_if import arm_pkg::*; ();

	reg_idx_t rn_idx;
	reg_idx_t rm_idx;
	reg_idx_t rd_idx;
	word_t rn_data;
	word_t rm_data;
	word_t rd_data; // store data
	logic wr_en;
	reg_idx_t wr_idx;
	word_t wr_data;

	modport ctrl (output rn_idx, rm_idx, rd_idx, wr_en, wr_idx, wr_data,
		input rn_data, rd_data);
	modport regs (input rn_idx, rm_idx, rd_idx, wr_en, wr_idx, wr_data,
		output rn_data, rm_data, rd_data);
	modport dp (input rn_data, rm_data);

endinterface

// File: hw/arm_pkg.sv
package arm_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_idx_t;
	typedef logic [3:0] flags_t; // n z c v
	typedef logic [3:0] cond_t;
	typedef logic [3:0] alu_op_t;
	typedef logic [1:0] shift_t;

	typedef enum logic [1:0] {
		ST_INIT,
		ST_FETCH,
		ST_EXEC
	} ctrl_state_e;

	localparam word_t RESET_PC = 32'h0800_0000; // first fetch
	localparam word_t PC_STEP = 32'd4;
	localparam word_t PC_READ_AHEAD = 32'd8; // r15 reads as pc + 8

	localparam alu_op_t OP_AND = 4'h0;
	localparam alu_op_t OP_EOR = 4'h1;
	localparam alu_op_t OP_SUB = 4'h2;
	localparam alu_op_t OP_RSB = 4'h3;
	localparam alu_op_t OP_ADD = 4'h4;
	localparam alu_op_t OP_ADC = 4'h5;
	localparam alu_op_t OP_SBC = 4'h6;
	localparam alu_op_t OP_RSC = 4'h7;
	localparam alu_op_t OP_TST = 4'h8;
	localparam alu_op_t OP_TEQ = 4'h9;
	localparam alu_op_t OP_CMP = 4'ha;
	localparam alu_op_t OP_CMN = 4'hb;
	localparam alu_op_t OP_ORR = 4'hc;
	localparam alu_op_t OP_MOV = 4'hd;
	localparam alu_op_t OP_BIC = 4'he;
	localparam alu_op_t OP_MVN = 4'hf;

	localparam reg_idx_t LR_IDX = 4'd14; // link register for bl

endpackage
